// File: hdl/core_pkg.sv
package core_pkg;

	// data or address word
	typedef logic [31:0] word_t;

	// {regnum[4:0], sel[2:0]}, only sel 0 is implemented
	typedef logic [7:0] reg_addr_t;

	// raw exception flags from the pipeline
	typedef logic [5:0] exc_flags_t;

	// bit positions inside exc_flags_t
	localparam int EXF_ADEF = 0;
	localparam int EXF_RI   = 1;
	localparam int EXF_OV   = 2;
	localparam int EXF_BP   = 3;
	localparam int EXF_SYS  = 4;
	// data address error, store when mem_write is high
	localparam int EXF_ADED = 5;

endpackage

// File: hdl/cp0_pkg.sv
package cp0_pkg;

	typedef logic [4:0] exc_code_t;
	typedef logic [4:0] cp0_regnum_t;
	// status.im and cause.ip
	typedef logic [7:0] irq_mask_t;

	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;

	localparam cp0_regnum_t REG_BADVADDR = 5'd8;
	localparam cp0_regnum_t REG_COUNT    = 5'd9;
	localparam cp0_regnum_t REG_COMPARE  = 5'd11;
	localparam cp0_regnum_t REG_STATUS   = 5'd12;
	localparam cp0_regnum_t REG_CAUSE    = 5'd13;
	localparam cp0_regnum_t REG_EPC      = 5'd14;
	localparam cp0_regnum_t REG_PRID     = 5'd15;
	localparam cp0_regnum_t REG_CONFIG   = 5'd16;

	// cu0, bev, im, um, erl/exl/ie
	localparam logic [31:0] STATUS_WMASK = 32'h1040_ff17;
	// iv and the two software ip bits
	localparam logic [31:0] CAUSE_WMASK  = 32'h0080_0300;

	// field positions
	localparam int ST_IE  = 0;
	localparam int ST_EXL = 1;
	localparam int CA_BD  = 31;
	localparam int CA_TI  = 30;

	// badvaddr source select
	localparam logic [1:0] BVA_NONE = 2'd0;
	localparam logic [1:0] BVA_PC   = 2'd1;
	localparam logic [1:0] BVA_ADDR = 2'd2;

endpackage

// File: hdl/cp0_exc_decode.sv
`timescale 1ns/1ps

module cp0_exc_decode (
	input  logic                 irq_req,
	input  core_pkg::exc_flags_t exc_flags,
	input  logic                 mem_write,
	output cp0_pkg::exc_code_t   exc_code,
	output logic [1:0]           badvaddr_sel
);
	import core_pkg::*;
	import cp0_pkg::*;

	// fixed priority, interrupt first
	always_comb begin
		exc_code = EXC_INT;
		badvaddr_sel = BVA_NONE;
		if (irq_req) begin
			exc_code = EXC_INT;
		end else if (exc_flags[EXF_ADEF]) begin
			// fetch side, faulting address is the pc itself
			exc_code = EXC_ADEL;
			badvaddr_sel = BVA_PC;
		end else if (exc_flags[EXF_RI]) begin
			exc_code = EXC_RI;
		end else if (exc_flags[EXF_OV]) begin
			exc_code = EXC_OV;
		end else if (exc_flags[EXF_BP]) begin
			exc_code = EXC_BP;
		end else if (exc_flags[EXF_SYS]) begin
			exc_code = EXC_SYS;
		end else if (exc_flags[EXF_ADED]) begin
			// load or store decided by the access direction
			if (mem_write) begin
				exc_code = EXC_ADES;
			end else begin
				exc_code = EXC_ADEL;
			end
			badvaddr_sel = BVA_ADDR;
		end
	end

endmodule

// File: hdl/cp0_int_ctrl.sv
`timescale 1ns/1ps

module cp0_int_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  logic [5:0]         ext_int,
	input  logic [1:0]         ip_soft,
	input  logic               ti,
	input  cp0_pkg::irq_mask_t im,
	input  logic               ie,
	input  logic               exl,
	input  logic               inter_valid,
	output logic               irq_req,
	output logic               irq_take
);
	import cp0_pkg::*;

	irq_mask_t pending;
	logic saved;

	// timer shares line 7 with the top external input
	assign pending = {ext_int, ip_soft} | {ti, 7'b0};
	assign irq_req = ie & ~exl & (|(pending & im));

	// a held request is still subject to ie and exl
	assign irq_take = (irq_req | (saved & ie & ~exl)) & inter_valid;

	// remember a request the pipeline could not take yet
	always_ff @(posedge clk) begin
		if (reset) begin
			saved <= 1'b0;
		end else if (inter_valid) begin
			saved <= 1'b0;
		end else if (irq_req) begin
			saved <= 1'b1;
		end
	end

endmodule

// File: hdl/cp0_regfile.sv
`timescale 1ns/1ps

module cp0_regfile #(
	parameter int              COUNT_DIV  = 2,
	parameter core_pkg::word_t PRID_RESET = 32'h0001_8000
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                write_valid,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data,
	input  logic                exc_valid,
	input  logic                irq_take,
	input  cp0_pkg::exc_code_t  exc_code,
	input  logic [1:0]          badvaddr_sel,
	input  core_pkg::word_t     pc,
	input  core_pkg::word_t     bad_addr,
	input  core_pkg::word_t     int_pc,
	input  logic                in_slot,
	input  logic                is_eret,
	output core_pkg::word_t     status,
	output core_pkg::word_t     cause,
	output core_pkg::word_t     epc,
	output core_pkg::word_t     count,
	output core_pkg::word_t     compare,
	output core_pkg::word_t     badvaddr,
	output core_pkg::word_t     prid,
	output core_pkg::word_t     config0
);
	import core_pkg::*;
	import cp0_pkg::*;

	localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic entry;
	logic wr_en;
	cp0_regnum_t wr_num;
	word_t status_nxt;
	word_t cause_nxt;
	word_t epc_nxt;
	word_t count_nxt;
	word_t compare_nxt;
	word_t badvaddr_nxt;
	word_t config_nxt;

	assign wr_num = wr_addr[7:3];
	assign entry = exc_valid | irq_take;
	// entry wins over mtc0, non-zero selects are dropped
	assign wr_en = write_valid & ~entry & (wr_addr[2:0] == 3'b000);
	assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

	// count prescaler
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_comb begin
		status_nxt = status;
		cause_nxt = cause;
		epc_nxt = epc;
		count_nxt = count;
		compare_nxt = compare;
		badvaddr_nxt = badvaddr;
		config_nxt = config0;

		if (tick) begin
			count_nxt = count + 32'd1;
		end
		// timer flag is sticky until compare is rewritten
		if (count == compare) begin
			cause_nxt[CA_TI] = 1'b1;
		end

		if (entry) begin
			cause_nxt[6:2] = exc_code;
			case (badvaddr_sel)
				BVA_PC:   badvaddr_nxt = pc;
				BVA_ADDR: badvaddr_nxt = bad_addr;
				default:  ;
			endcase
			// nested entry keeps the first return address
			if (!status[ST_EXL]) begin
				if (irq_take) begin
					epc_nxt = int_pc;
					cause_nxt[CA_BD] = 1'b0;
				end else if (in_slot) begin
					// restart at the branch
					epc_nxt = pc - 32'd4;
					cause_nxt[CA_BD] = 1'b1;
				end else begin
					epc_nxt = pc;
					cause_nxt[CA_BD] = 1'b0;
				end
			end
			status_nxt[ST_EXL] = 1'b1;
		end else if (wr_en) begin
			case (wr_num)
				REG_COUNT:   count_nxt = wr_data;
				REG_COMPARE: begin
					compare_nxt = wr_data;
					cause_nxt[CA_TI] = 1'b0;
				end
				REG_STATUS:  status_nxt = (status & ~STATUS_WMASK) | (wr_data & STATUS_WMASK);
				REG_CAUSE:   cause_nxt = (cause_nxt & ~CAUSE_WMASK) | (wr_data & CAUSE_WMASK);
				REG_EPC:     epc_nxt = wr_data;
				REG_CONFIG:  config_nxt[2:0] = wr_data[2:0];
				default:     ;
			endcase
		end

		// eret has the last word on exl
		if (is_eret) begin
			status_nxt[ST_EXL] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			status <= '0;
			cause <= '0;
			epc <= '0;
			count <= '0;
			compare <= '0;
			badvaddr <= '0;
			prid <= PRID_RESET;
			config0 <= '0;
		end else begin
			status <= status_nxt;
			cause <= cause_nxt;
			epc <= epc_nxt;
			count <= count_nxt;
			compare <= compare_nxt;
			badvaddr <= badvaddr_nxt;
			config0 <= config_nxt;
		end
	end

endmodule

// File: hdl/cp0_read_port.sv
`timescale 1ns/1ps

module cp0_read_port (
	input  core_pkg::reg_addr_t rd_addr,
	input  core_pkg::reg_addr_t rd_addr_m,
	input  core_pkg::word_t     status,
	input  core_pkg::word_t     cause,
	input  core_pkg::word_t     epc,
	input  core_pkg::word_t     count,
	input  core_pkg::word_t     compare,
	input  core_pkg::word_t     badvaddr,
	input  core_pkg::word_t     prid,
	input  core_pkg::word_t     config0,
	input  logic                exc_valid,
	input  logic                irq_take,
	output core_pkg::word_t     rd_data,
	output core_pkg::word_t     rd_data_m,
	output core_pkg::word_t     epc_out,
	output logic                trap
);
	import core_pkg::*;
	import cp0_pkg::*;

	// shared decoder for both ports
	function automatic word_t read_reg(input reg_addr_t addr);
		word_t val;
		val = '0;
		if (addr[2:0] == 3'b000) begin
			case (cp0_regnum_t'(addr[7:3]))
				REG_BADVADDR: val = badvaddr;
				REG_COUNT:    val = count;
				REG_COMPARE:  val = compare;
				REG_STATUS:   val = status;
				REG_CAUSE:    val = cause;
				REG_EPC:      val = epc;
				REG_PRID:     val = prid;
				REG_CONFIG:   val = config0;
				default:      val = '0;
			endcase
		end
		return val;
	endfunction

	// decode stage port
	always_comb begin
		rd_data = read_reg(rd_addr);
	end

	// memory stage port
	always_comb begin
		rd_data_m = read_reg(rd_addr_m);
	end

	// redirect to fetch
	assign trap = exc_valid | irq_take;
	assign epc_out = epc;

endmodule

// File: hdl/cp0_unit.sv
`timescale 1ns/1ps

module cp0_unit #(
	parameter int              COUNT_DIV  = 2,
	parameter core_pkg::word_t PRID_RESET = 32'h0001_8000
) (
	input  logic                 clk,
	input  logic                 reset,
	input  core_pkg::reg_addr_t  rd_addr,
	input  core_pkg::reg_addr_t  rd_addr_m,
	input  logic                 write_valid,
	input  core_pkg::reg_addr_t  wr_addr,
	input  core_pkg::word_t      wr_data,
	input  logic                 exc_valid,
	input  core_pkg::exc_flags_t exc_flags,
	input  core_pkg::word_t      pc,
	input  logic                 in_slot,
	input  core_pkg::word_t      bad_addr,
	input  logic                 mem_write,
	input  logic                 is_eret,
	input  logic [5:0]           ext_int,
	input  logic                 inter_valid,
	input  core_pkg::word_t      int_pc,
	output core_pkg::word_t      rd_data,
	output core_pkg::word_t      rd_data_m,
	output core_pkg::word_t      epc_out,
	output logic                 trap,
	output logic                 irq_req
);
	import core_pkg::*;
	import cp0_pkg::*;

	exc_code_t exc_code;
	logic [1:0] badvaddr_sel;
	logic irq_take;
	word_t status;
	word_t cause;
	word_t epc;
	word_t count;
	word_t compare;
	word_t badvaddr;
	word_t prid;
	word_t config0;

	// interrupt code only when the request is actually taken
	cp0_exc_decode exc_decode_i (
		.irq_req      (irq_take),
		.exc_flags    (exc_flags),
		.mem_write    (mem_write),
		.exc_code     (exc_code),
		.badvaddr_sel (badvaddr_sel)
	);

	cp0_int_ctrl int_ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.ext_int     (ext_int),
		.ip_soft     (cause[9:8]),
		.ti          (cause[CA_TI]),
		.im          (status[15:8]),
		.ie          (status[ST_IE]),
		.exl         (status[ST_EXL]),
		.inter_valid (inter_valid),
		.irq_req     (irq_req),
		.irq_take    (irq_take)
	);

	cp0_regfile #(
		.COUNT_DIV  (COUNT_DIV),
		.PRID_RESET (PRID_RESET)
	) regfile_i (
		.clk          (clk),
		.reset        (reset),
		.write_valid  (write_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.exc_valid    (exc_valid),
		.irq_take     (irq_take),
		.exc_code     (exc_code),
		.badvaddr_sel (badvaddr_sel),
		.pc           (pc),
		.bad_addr     (bad_addr),
		.int_pc       (int_pc),
		.in_slot      (in_slot),
		.is_eret      (is_eret),
		.status       (status),
		.cause        (cause),
		.epc          (epc),
		.count        (count),
		.compare      (compare),
		.badvaddr     (badvaddr),
		.prid         (prid),
		.config0      (config0)
	);

	cp0_read_port read_port_i (
		.rd_addr   (rd_addr),
		.rd_addr_m (rd_addr_m),
		.status    (status),
		.cause     (cause),
		.epc       (epc),
		.count     (count),
		.compare   (compare),
		.badvaddr  (badvaddr),
		.prid      (prid),
		.config0   (config0),
		.exc_valid (exc_valid),
		.irq_take  (irq_take),
		.rd_data   (rd_data),
		.rd_data_m (rd_data_m),
		.epc_out   (epc_out),
		.trap      (trap)
	);

endmodule

// File: dv/cp0_unit_assertions.sv
`timescale 1ns/1ps

module cp0_unit_assertions (
	input logic clk,
	input logic reset,
	input logic trap,
	input logic exc_valid,
	input logic inter_valid,
	input logic is_eret,
	input logic exl
);

	no_trap_in_reset: assert property (@(posedge clk) reset |-> !trap)
		else $error("trap high during reset");

	// every exception redirects fetch
	trap_on_exc: assert property (@(posedge clk) disable iff (reset) exc_valid |-> trap)
		else $error("trap low while exc_valid is high");

	// without an exception only an interrupt the pipeline can accept redirects
	trap_source: assert property (@(posedge clk) disable iff (reset)
		trap && !exc_valid |-> inter_valid)
		else $error("trap without exc_valid or inter_valid");

	// eret in the same cycle would win over entry
	exl_after_trap: assert property (@(posedge clk) disable iff (reset)
		trap && !is_eret |=> exl)
		else $error("exl not set after trap");

	exl_after_eret: assert property (@(posedge clk) disable iff (reset) is_eret |=> !exl)
		else $error("exl not cleared after eret");

endmodule

bind cp0_unit cp0_unit_assertions assertions_i (
	.clk         (clk),
	.reset       (reset),
	.trap        (trap),
	.exc_valid   (exc_valid),
	.inter_valid (inter_valid),
	.is_eret     (is_eret),
	.exl         (status[cp0_pkg::ST_EXL])
);

// File: dv/cp0_unit_tb.sv
`timescale 1ns/1ps

module cp0_unit_tb;
	import core_pkg::*;
	import cp0_pkg::*;

	localparam int COUNT_DIV = 2;
	localparam word_t PRID = 32'h0001_8020;
	localparam word_t STATUS_MASK = 32'h1040_ff17;
	localparam word_t CAUSE_MASK = 32'h0080_0300;
	localparam word_t CONFIG_MASK = 32'h0000_0007;
	// all tests together take about 150 cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset;
	reg_addr_t rd_addr;
	reg_addr_t rd_addr_m;
	logic write_valid;
	reg_addr_t wr_addr;
	word_t wr_data;
	logic exc_valid;
	exc_flags_t exc_flags;
	word_t pc;
	logic in_slot;
	word_t bad_addr;
	logic mem_write;
	logic is_eret;
	logic [5:0] ext_int;
	logic inter_valid;
	word_t int_pc;
	word_t rd_data;
	word_t rd_data_m;
	word_t epc_out;
	logic trap;
	logic irq_req;

	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	// badvaddr as the decode rule predicts it
	word_t bva_exp = '0;

	cp0_unit #(
		.COUNT_DIV  (COUNT_DIV),
		.PRID_RESET (PRID)
	) cp0_unit_i (
		.clk         (clk),
		.reset       (reset),
		.rd_addr     (rd_addr),
		.rd_addr_m   (rd_addr_m),
		.write_valid (write_valid),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.exc_valid   (exc_valid),
		.exc_flags   (exc_flags),
		.pc          (pc),
		.in_slot     (in_slot),
		.bad_addr    (bad_addr),
		.mem_write   (mem_write),
		.is_eret     (is_eret),
		.ext_int     (ext_int),
		.inter_valid (inter_valid),
		.int_pc      (int_pc),
		.rd_data     (rd_data),
		.rd_data_m   (rd_data_m),
		.epc_out     (epc_out),
		.trap        (trap),
		.irq_req     (irq_req)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check(input string name, input word_t got, input word_t exp);
		assert (got === exp) begin
			pass_cnt++;
		end else begin
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			fail_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		$display("%s finished, %0d failed checks", name, fail_cnt - start);
	endtask

	task automatic mtc0(input cp0_regnum_t num, input logic [2:0] sel, input word_t data);
		write_valid = 1'b1;
		wr_addr = {num, sel};
		wr_data = data;
		next_cycle();
		write_valid = 1'b0;
	endtask

	task automatic read_reg(input cp0_regnum_t num, output word_t val);
		rd_addr = {num, 3'b000};
		#1;
		val = rd_data;
		next_cycle();
	endtask

	// both ports look at the same register
	task automatic check_reg(input cp0_regnum_t num, input logic [2:0] sel, input word_t exp,
			input string name);
		rd_addr = {num, sel};
		rd_addr_m = {num, sel};
		#1;
		check({name, " rd_data"}, rd_data, exp);
		check({name, " rd_data_m"}, rd_data_m, exp);
		next_cycle();
	endtask

	task automatic check_irq(input logic exp_req, input logic exp_trap);
		#1;
		check("irq_req", {31'b0, irq_req}, {31'b0, exp_req});
		check("trap", {31'b0, trap}, {31'b0, exp_trap});
		next_cycle();
	endtask

	task automatic take_exc(input exc_flags_t flags, input logic mw, input word_t pc_v,
			input logic slot, input word_t bad_v);
		exc_valid = 1'b1;
		exc_flags = flags;
		mem_write = mw;
		pc = pc_v;
		in_slot = slot;
		bad_addr = bad_v;
		#1;
		check("trap", {31'b0, trap}, 32'd1);
		next_cycle();
		exc_valid = 1'b0;
		exc_flags = '0;
		mem_write = 1'b0;
		in_slot = 1'b0;
	endtask

	task automatic do_eret();
		is_eret = 1'b1;
		next_cycle();
		is_eret = 1'b0;
	endtask

	// status and cause back to zero, then let a pulse drop any held request
	task automatic quiet_irq();
		mtc0(REG_STATUS, 3'd0, '0);
		mtc0(REG_CAUSE, 3'd0, '0);
		inter_valid = 1'b1;
		next_cycle();
		inter_valid = 1'b0;
	endtask

	task automatic test_write_masks();
		int start;
		word_t d;
		start = fail_cnt;
		// compare first so the timer flag left from reset is cleared
		d = $urandom | 32'h8000_0000;
		mtc0(REG_COMPARE, 3'd0, d);
		check_reg(REG_COMPARE, 3'd0, d, "compare");
		d = $urandom;
		mtc0(REG_STATUS, 3'd0, d);
		check_reg(REG_STATUS, 3'd0, d & STATUS_MASK, "status");
		d = $urandom;
		mtc0(REG_CAUSE, 3'd0, d);
		check_reg(REG_CAUSE, 3'd0, d & CAUSE_MASK, "cause");
		d = $urandom;
		mtc0(REG_EPC, 3'd0, d);
		check_reg(REG_EPC, 3'd0, d, "epc");
		mtc0(REG_EPC, 3'd1, $urandom);
		check_reg(REG_EPC, 3'd0, d, "epc after sel 1 write");
		d = $urandom;
		mtc0(REG_CONFIG, 3'd0, d);
		check_reg(REG_CONFIG, 3'd0, d & CONFIG_MASK, "config");
		mtc0(REG_BADVADDR, 3'd0, $urandom);
		check_reg(REG_BADVADDR, 3'd0, '0, "badvaddr");
		mtc0(REG_PRID, 3'd0, $urandom);
		check_reg(REG_PRID, 3'd0, PRID, "prid");
		check_reg(5'd0, 3'd0, '0, "reg 0");
		check_reg(5'd3, 3'd0, '0, "reg 3");
		check_reg(5'd20, 3'd0, '0, "reg 20");
		check_reg(REG_STATUS, 3'd1, '0, "status sel 1");
		quiet_irq();
		report_test("write_masks", start);
	endtask

	task automatic exc_case(input exc_flags_t flags, input logic mw, input exc_code_t code,
			input int bsel);
		word_t pc_v;
		word_t bad_v;
		word_t v;
		pc_v = $urandom & 32'hffff_fffc;
		bad_v = $urandom;
		take_exc(flags, mw, pc_v, 1'b0, bad_v);
		if (bsel == 1) begin
			bva_exp = pc_v;
		end else if (bsel == 2) begin
			bva_exp = bad_v;
		end
		read_reg(REG_CAUSE, v);
		check("cause.exccode", {27'b0, v[6:2]}, {27'b0, code});
		check_reg(REG_BADVADDR, 3'd0, bva_exp, "badvaddr");
	endtask

	task automatic test_exc_priority();
		int start;
		start = fail_cnt;
		// flag bits: 0 fetch adel, 1 ri, 2 ov, 3 bp, 4 sys, 5 data address error
		exc_case(6'b111111, 1'b1, EXC_ADEL, 1);
		exc_case(6'b111110, 1'b1, EXC_RI, 0);
		exc_case(6'b111100, 1'b0, EXC_OV, 0);
		exc_case(6'b111000, 1'b0, EXC_BP, 0);
		exc_case(6'b110000, 1'b1, EXC_SYS, 0);
		exc_case(6'b100000, 1'b0, EXC_ADEL, 2);
		exc_case(6'b100000, 1'b1, EXC_ADES, 2);
		do_eret();
		report_test("exc_priority", start);
	endtask

	task automatic test_epc_bd();
		int start;
		word_t p;
		word_t v;
		start = fail_cnt;
		p = $urandom & 32'hffff_fffc;
		take_exc(6'b010000, 1'b0, p, 1'b0, '0);
		check("epc_out", epc_out, p);
		check_reg(REG_EPC, 3'd0, p, "epc no slot");
		read_reg(REG_CAUSE, v);
		check("cause.bd", {31'b0, v[31]}, 32'd0);
		do_eret();
		read_reg(REG_STATUS, v);
		check("status.exl after eret", {31'b0, v[1]}, 32'd0);
		p = $urandom & 32'hffff_fffc;
		take_exc(6'b010000, 1'b0, p, 1'b1, '0);
		check_reg(REG_EPC, 3'd0, p - 32'd4, "epc in slot");
		read_reg(REG_CAUSE, v);
		check("cause.bd", {31'b0, v[31]}, 32'd1);
		// nested exception must keep the first epc
		take_exc(6'b000010, 1'b0, $urandom & 32'hffff_fffc, 1'b0, '0);
		check_reg(REG_EPC, 3'd0, p - 32'd4, "epc nested");
		do_eret();
		read_reg(REG_STATUS, v);
		check("status.exl after eret", {31'b0, v[1]}, 32'd0);
		report_test("epc_bd", start);
	endtask

	task automatic test_interrupts();
		int start;
		word_t ipc;
		word_t v;
		start = fail_cnt;
		ipc = $urandom & 32'hffff_fffc;
		// ie and im0, then software ip0
		mtc0(REG_STATUS, 3'd0, 32'h0000_0101);
		mtc0(REG_CAUSE, 3'd0, 32'h0000_0100);
		check_irq(1'b1, 1'b0);
		repeat (3) next_cycle();
		check_irq(1'b1, 1'b0);
		// request goes away, the held flag still has to deliver it
		mtc0(REG_CAUSE, 3'd0, '0);
		check_irq(1'b0, 1'b0);
		inter_valid = 1'b1;
		int_pc = ipc;
		#1;
		check("trap on inter_valid", {31'b0, trap}, 32'd1);
		next_cycle();
		inter_valid = 1'b0;
		check_reg(REG_EPC, 3'd0, ipc, "epc interrupt");
		read_reg(REG_CAUSE, v);
		check("cause.exccode", {27'b0, v[6:2]}, {27'b0, EXC_INT});
		read_reg(REG_STATUS, v);
		check("status.exl", {31'b0, v[1]}, 32'd1);
		mtc0(REG_CAUSE, 3'd0, 32'h0000_0100);
		check_irq(1'b0, 1'b0);
		do_eret();
		check_irq(1'b1, 1'b0);
		quiet_irq();
		report_test("interrupts", start);
	endtask

	task automatic test_timer();
		int start;
		int i;
		int delta;
		int limit;
		logic found;
		word_t c0;
		word_t c1;
		word_t v;
		start = fail_cnt;
		limit = 6 * COUNT_DIV + 2;
		mtc0(REG_COUNT, 3'd0, 32'h0000_1000);
		check_reg(REG_COUNT, 3'd0, 32'h0000_1000, "count after write");
		read_reg(REG_COUNT, c0);
		repeat (19) next_cycle();
		read_reg(REG_COUNT, c1);
		delta = int'(c1 - c0);
		assert (delta >= 20 / COUNT_DIV - 1 && delta <= 20 / COUNT_DIV + 1) begin
			pass_cnt++;
		end else begin
			$display("Error at %0t ns: count delta got %0d expected %0d +/- 1", $time, delta,
				20 / COUNT_DIV);
			fail_cnt++;
		end
		read_reg(REG_COUNT, c0);
		mtc0(REG_COMPARE, 3'd0, c0 + 32'd4);
		read_reg(REG_CAUSE, v);
		check("cause.ti before match", {31'b0, v[30]}, 32'd0);
		found = 1'b0;
		for (i = 0; i < limit && !found; i++) begin
			read_reg(REG_CAUSE, v);
			found = v[30];
		end
		assert (found) begin
			pass_cnt++;
		end else begin
			$display("timer flag was not set within %0d cycles of the compare match", limit);
			fail_cnt++;
		end
		mtc0(REG_COMPARE, 3'd0, c0 + 32'h0100_0000);
		read_reg(REG_CAUSE, v);
		check("cause.ti after compare write", {31'b0, v[30]}, 32'd0);
		report_test("timer", start);
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h6fec));
		reset = 1'b1;
		rd_addr = '0;
		rd_addr_m = '0;
		write_valid = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		exc_valid = 1'b0;
		exc_flags = '0;
		pc = '0;
		in_slot = 1'b0;
		bad_addr = '0;
		mem_write = 1'b0;
		is_eret = 1'b0;
		ext_int = '0;
		inter_valid = 1'b0;
		int_pc = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_write_masks();
		test_exc_priority();
		test_epc_bd();
		test_interrupts();
		test_timer();
		$display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: compile.f
hdl/core_pkg.sv
hdl/cp0_pkg.sv
hdl/cp0_exc_decode.sv
hdl/cp0_int_ctrl.sv
hdl/cp0_regfile.sv
hdl/cp0_read_port.sv
hdl/cp0_unit.sv
dv/cp0_unit_assertions.sv
dv/cp0_unit_tb.sv

// File: Bender.yml
package:
  name: cp0_unit

sources:
  # packages first, then the design from the leaves up
  - files:
      - hdl/core_pkg.sv
      - hdl/cp0_pkg.sv
      - hdl/cp0_exc_decode.sv
      - hdl/cp0_int_ctrl.sv
      - hdl/cp0_regfile.sv
      - hdl/cp0_read_port.sv
      - hdl/cp0_unit.sv

  - target: test
    files:
      - dv/cp0_unit_assertions.sv
      - dv/cp0_unit_tb.sv
